// File: tb.f
design/game_pkg.sv
design/trex_pkg.sv
design/box_if.sv
design/frame_timer.sv
design/trex.sv
design/obstacle_scroll.sv
design/collision_check.sv
design/runner_game.sv
dv/tb_runner_game.sv

// File: Bender.yml
package:
  name: runner_game

sources:
  - design/game_pkg.sv
  - design/trex_pkg.sv
  - design/box_if.sv
  - design/frame_timer.sv
  - design/trex.sv
  - design/obstacle_scroll.sv
  - design/collision_check.sv
  - design/runner_game.sv
  - target: test
    files:
      - dv/tb_runner_game.sv

// File: dv/tb_runner_game.sv
module tb_runner_game;
    timeunit 1ns;
    timeprecision 1ps;

    import game_pkg::*;
    import trex_pkg::*;

    localparam int CLK_PER_FRAME = 8;
    localparam int CLK_PERIOD = 20;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_ROWS = 13;
    localparam int CRASH_ROW = 9;
    localparam logic [31:0] SEED = 32'hc22f_d13e;

    logic       clk;
    logic       rst;
    logic [3:0] speed;
    logic       jump;
    logic       duck;
    pos_t       x_pos;
    pos_t       y_pos;
    frame_t     frame;
    pos_t       obstacle_x;

    // Stimulus table, one row per phase of the game.
    logic row_jump [NUM_ROWS];
    logic row_duck [NUM_ROWS];
    logic row_rand [NUM_ROWS];
    int   row_speed [NUM_ROWS];
    int   row_frames [NUM_ROWS];
    logic table_ready;

    // Reference model of the game, one step per frame.
    state_t m_state;
    frame_t m_frame;
    int     m_anim;
    int     m_y;
    int     m_vel;
    int     m_acc;
    int     m_obst_x;
    logic   m_crash;

    int   value_errors;
    int   other_errors;
    int   compare_count;
    int   frame_idx;
    int   crash_row;
    logic overlap_reported;

    runner_game #(
        .CLK_PER_FRAME(CLK_PER_FRAME)
    ) u_runner_game (
        .clk       (clk),
        .rst       (rst),
        .speed     (speed),
        .jump      (jump),
        .duck      (duck),
        .x_pos     (x_pos),
        .y_pos     (y_pos),
        .frame     (frame),
        .obstacle_x(obstacle_x)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic set_row(input int idx, input logic j, input logic d, input logic rnd,
                           input int spd, input int n);
        row_jump[idx] = j;
        row_duck[idx] = d;
        row_rand[idx] = rnd;
        row_speed[idx] = spd;
        row_frames[idx] = n;
    endtask

    task automatic load_table();
        // Waiting through a full anim period, duck has no effect here.
        set_row(0, 1'b0, 1'b0, 1'b0, 0, 30);
        set_row(1, 1'b0, 1'b1, 1'b0, 0, 32);
        // Jump from waiting, then land and run.
        set_row(2, 1'b1, 1'b0, 1'b0, 0, 1);
        set_row(3, 1'b0, 1'b0, 1'b0, 0, 36);
        // Jump at full speed, the cactus passes under it.
        set_row(4, 1'b1, 1'b0, 1'b0, 15, 1);
        set_row(5, 1'b0, 1'b0, 1'b0, 15, 33);
        set_row(6, 1'b0, 1'b0, 1'b0, 7, 12);
        // Short duck with random speeds while the cactus is far away.
        set_row(7, 1'b0, 1'b1, 1'b1, 0, 6);
        set_row(8, 1'b0, 1'b0, 1'b1, 0, 2);
        // Run into the cactus, then poke the frozen game.
        set_row(CRASH_ROW, 1'b0, 1'b0, 1'b0, 15, 16);
        set_row(10, 1'b1, 1'b0, 1'b0, 15, 4);
        set_row(11, 1'b0, 1'b1, 1'b0, 9, 4);
        set_row(12, 1'b1, 1'b1, 1'b0, 3, 4);
        table_ready = 1'b1;
    endtask

    function automatic int total_frames();
        int sum;
        sum = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            sum += row_frames[r];
        end
        return sum;
    endfunction

    // Strict overlap, touching edges do not collide.
    function automatic logic boxes_overlap(input int ax, input int ay, input int aw, input int ah,
                                           input int bx, input int by, input int bw, input int bh);
        return (ax < bx + bw) && (bx < ax + aw) && (ay < by + bh) && (by < ay + ah);
    endfunction

    task automatic model_reset();
        m_state = WAITING;
        m_frame = WAITING0;
        m_anim = 0;
        m_y = GROUND_Y_POS;
        m_vel = 0;
        m_acc = 0;
        m_obst_x = SCREEN_WIDTH;
        m_crash = boxes_overlap(START_X_POS, m_y, WIDTH, HEIGHT,
                                m_obst_x, OBST_Y_POS, OBST_WIDTH, OBST_HEIGHT);
    endtask

    task automatic model_frame(input logic j, input logic d, input int s, input int r);
        state_t nxt;
        logic   moving;
        int     y_old;
        int     step;
        int     box_y;
        int     box_w;
        int     box_h;

        moving = (m_state == RUNNING) || (m_state == JUMPING) || (m_state == DUCKING);
        case (m_state)
            WAITING: nxt = j ? JUMPING : WAITING;
            RUNNING: nxt = j ? JUMPING : (d ? DUCKING : RUNNING);
            JUMPING: nxt = (m_y > GROUND_Y_POS) ? RUNNING : JUMPING;
            DUCKING: nxt = d ? DUCKING : RUNNING;
            default: nxt = CRASHED;
        endcase
        // The crash seen now comes from the boxes of the previous frame.
        if (m_crash && moving) begin
            nxt = CRASHED;
        end

        if (m_state != JUMPING && nxt == JUMPING) begin
            m_vel = INITIAL_JUMP_VELOCITY - (s >> 3);
            m_acc = 0;
        end else if (m_state == JUMPING && nxt == RUNNING) begin
            m_y = GROUND_Y_POS;
        end else if (m_state == JUMPING && nxt == JUMPING) begin
            y_old = m_y;
            m_y = m_y + m_vel;
            m_acc = m_acc + GRAVITY;
            if (m_acc >= 10) begin
                m_acc = m_acc - 10;
                m_vel = m_vel + 1;
            end
            if (y_old < MIN_JUMP_HEIGHT && m_vel < DROP_VELOCITY) begin
                m_vel = DROP_VELOCITY;
            end
        end

        case (nxt)
            WAITING: m_frame = (m_anim >= 30) ? WAITING0 : WAITING1;
            RUNNING: m_frame = ((m_anim % 10) < 5) ? RUNNING0 : RUNNING1;
            JUMPING: m_frame = JUMPING0;
            DUCKING: m_frame = ((m_anim % 20) < 10) ? DUCKING0 : DUCKING1;
            default: m_frame = CRASHED0;
        endcase

        if (moving) begin
            step = BASE_SCROLL + s;
            m_obst_x = (m_obst_x < step) ? SCREEN_WIDTH : m_obst_x - step;
        end

        if (nxt == CRASHED && m_state != CRASHED) begin
            crash_row = r;
            $display("Model: crash at frame %0d, row %0d", frame_idx, r);
        end
        m_state = nxt;
        m_anim = (m_anim + 1) % FRAME_COUNT;

        if (nxt == DUCKING) begin
            box_y = m_y + HEIGHT - HEIGHT_DUCK;
            box_w = WIDTH_DUCK;
            box_h = HEIGHT_DUCK;
        end else begin
            box_y = m_y;
            box_w = WIDTH;
            box_h = HEIGHT;
        end
        m_crash = boxes_overlap(START_X_POS, box_y, box_w, box_h,
                                m_obst_x, OBST_Y_POS, OBST_WIDTH, OBST_HEIGHT);
        if (m_crash && !overlap_reported) begin
            overlap_reported = 1'b1;
            $display("Model: first overlap at frame %0d, obstacle x %0d", frame_idx, m_obst_x);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        compare_count++;
        if (got !== exp) begin
            value_errors++;
            $display("ERR %s got 0x%0h expected 0x%0h at frame %0d", name, got, exp, frame_idx);
        end
    endtask

    task automatic compare_outputs();
        check_value("x_pos", 32'(x_pos), 32'(START_X_POS));
        check_value("y_pos", 32'(y_pos), 32'(m_y));
        check_value("frame", 32'(frame), 32'(m_frame));
        check_value("obstacle_x", 32'(obstacle_x), 32'(m_obst_x));
    endtask

    // One frame of stimulus, ending just after the tick edge.
    task automatic run_frame(input logic j, input logic d, input int s, input int r);
        @(posedge clk);
        jump <= j;
        duck <= d;
        speed <= 4'(s);
        repeat (CLK_PER_FRAME - 1) @(posedge clk);
        model_frame(j, d, s, r);
        @(negedge clk);
        compare_outputs();
        frame_idx++;
    endtask

    initial begin
        int timeout_ns;
        wait (table_ready === 1'b1);
        timeout_ns = (total_frames() + 4) * CLK_PER_FRAME * CLK_PERIOD
                     + (RESET_CYCLES + 20) * CLK_PERIOD;
        #(timeout_ns);
        $display("Timeout: the stimulus table did not finish within %0d ns", timeout_ns);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        int spd;
        rst = 1'b1;
        jump = 1'b0;
        duck = 1'b0;
        speed = '0;
        table_ready = 1'b0;
        value_errors = 0;
        other_errors = 0;
        compare_count = 0;
        frame_idx = 0;
        crash_row = -1;
        overlap_reported = 1'b0;
        void'($urandom(SEED));
        load_table();
        model_reset();

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        compare_outputs();
        // The first tick edge comes CLK_PER_FRAME + 1 edges after release.
        @(posedge clk);

        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int f = 0; f < row_frames[r]; f++) begin
                if (row_rand[r]) begin
                    spd = int'($urandom & 32'hf);
                end else begin
                    spd = row_speed[r];
                end
                run_frame(row_jump[r], row_duck[r], spd, r);
            end
        end

        if (crash_row != CRASH_ROW) begin
            other_errors++;
            $display("The model crashed in row %0d instead of the crash row %0d",
                     crash_row, CRASH_ROW);
        end
        $display("Summary: %0d compares, %0d value errors, %0d other errors",
                 compare_count, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: design/runner_game.sv
module runner_game #(
    parameter int CLK_PER_FRAME = 100_000_000 / 60
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [3:0]       speed,
    input  logic             jump,
    input  logic             duck,
    output game_pkg::pos_t   x_pos,
    output game_pkg::pos_t   y_pos,
    output trex_pkg::frame_t frame,
    output game_pkg::pos_t   obstacle_x
);
    logic       tick;
    logic [5:0] anim;
    logic       scroll;
    logic       crash;

    box_if trex_box ();
    box_if obst_box ();

    frame_timer #(
        .CLK_PER_FRAME(CLK_PER_FRAME)
    ) u_frame_timer (
        .clk (clk),
        .rst (rst),
        .tick(tick),
        .anim(anim)
    );

    trex u_trex (
        .clk   (clk),
        .rst   (rst),
        .tick  (tick),
        .anim  (anim),
        .speed (speed),
        .jump  (jump),
        .duck  (duck),
        .crash (crash),
        .x_pos (x_pos),
        .y_pos (y_pos),
        .frame (frame),
        .scroll(scroll),
        .box   (trex_box.source)
    );

    obstacle_scroll u_obstacle_scroll (
        .clk       (clk),
        .rst       (rst),
        .tick      (tick),
        .scroll    (scroll),
        .speed     (speed),
        .obstacle_x(obstacle_x),
        .box       (obst_box.source)
    );

    collision_check u_collision_check (
        .clk     (clk),
        .rst     (rst),
        .trex_box(trex_box.sink),
        .obst_box(obst_box.sink),
        .crash   (crash)
    );

endmodule

// File: design/collision_check.sv
module collision_check (
    input  logic clk,
    input  logic rst,
    box_if.sink  trex_box,
    box_if.sink  obst_box,
    output logic crash
);
    logic [10:0] trex_right;
    logic [10:0] trex_bottom;
    logic [10:0] obst_right;
    logic [10:0] obst_bottom;
    logic        overlap_x;
    logic        overlap_y;

    // One extra bit so the far edges cannot wrap.
    assign trex_right = {1'b0, trex_box.x} + {1'b0, trex_box.w};
    assign trex_bottom = {1'b0, trex_box.y} + {1'b0, trex_box.h};
    assign obst_right = {1'b0, obst_box.x} + {1'b0, obst_box.w};
    assign obst_bottom = {1'b0, obst_box.y} + {1'b0, obst_box.h};

    // Touching edges do not count.
    assign overlap_x = ({1'b0, trex_box.x} < obst_right) && ({1'b0, obst_box.x} < trex_right);
    assign overlap_y = ({1'b0, trex_box.y} < obst_bottom) && ({1'b0, obst_box.y} < trex_bottom);

    always_ff @(posedge clk) begin
        if (rst) begin
            crash <= 1'b0;
        end else begin
            crash <= overlap_x && overlap_y;
        end
    end

endmodule

// File: design/obstacle_scroll.sv
module obstacle_scroll (
    input  logic           clk,
    input  logic           rst,
    input  logic           tick,
    input  logic           scroll,
    input  logic [3:0]     speed,
    output game_pkg::pos_t obstacle_x,
    box_if.source          box
);
    import game_pkg::*;

    pos_t step;

    // Scroll distance per frame.
    assign step = pos_t'(BASE_SCROLL) + pos_t'(speed);

    always_ff @(posedge clk) begin
        if (rst) begin
            obstacle_x <= pos_t'(SCREEN_WIDTH);
        end else if (tick && scroll) begin
            // Past the left edge, start over at the right.
            if (obstacle_x < step) begin
                obstacle_x <= pos_t'(SCREEN_WIDTH);
            end else begin
                obstacle_x <= obstacle_x - step;
            end
        end
    end

    // The cactus only moves horizontally.
    assign box.x = obstacle_x;
    assign box.y = pos_t'(OBST_Y_POS);
    assign box.w = pos_t'(OBST_WIDTH);
    assign box.h = pos_t'(OBST_HEIGHT);

endmodule

// File: design/trex.sv
module trex (
    input  logic             clk,
    input  logic             rst,
    input  logic             tick,
    input  logic [5:0]       anim,
    input  logic [3:0]       speed,
    input  logic             jump,
    input  logic             duck,
    input  logic             crash,
    output game_pkg::pos_t   x_pos,
    output game_pkg::pos_t   y_pos,
    output trex_pkg::frame_t frame,
    output logic             scroll,
    box_if.source            box
);
    import game_pkg::*;
    import trex_pkg::*;

    state_t state;
    state_t next_state;
    frame_t next_frame;

    logic signed [7:0]  velocity;
    logic signed [7:0]  next_velocity;
    logic [4:0]         gravity_acc;
    logic [4:0]         next_gravity_acc;
    logic [4:0]         gravity_sum;
    logic signed [10:0] y_moved;
    pos_t               next_y;
    pos_t               next_box_y;
    pos_t               next_box_w;
    pos_t               next_box_h;

    // The runner never moves horizontally.
    assign x_pos = pos_t'(START_X_POS);

    assign scroll = (state == RUNNING) || (state == JUMPING) || (state == DUCKING);

    always_comb begin
        case (state)
            WAITING: next_state = jump ? JUMPING : WAITING;
            RUNNING: begin
                if (jump) begin
                    next_state = JUMPING;
                end else if (duck) begin
                    next_state = DUCKING;
                end else begin
                    next_state = RUNNING;
                end
            end
            JUMPING: next_state = (y_pos > pos_t'(GROUND_Y_POS)) ? RUNNING : JUMPING;
            DUCKING: next_state = duck ? DUCKING : RUNNING;
            CRASHED: next_state = CRASHED;
            default: next_state = WAITING;
        endcase

        if (crash && scroll) begin
            next_state = CRASHED;
        end
    end

    // Jump physics.
    always_comb begin
        gravity_sum = gravity_acc + 5'(GRAVITY);
        y_moved = $signed({1'b0, y_pos}) + velocity;
        next_y = y_pos;
        next_velocity = velocity;
        next_gravity_acc = gravity_acc;

        if (state != JUMPING && next_state == JUMPING) begin
            // Faster games give a slightly stronger takeoff.
            next_velocity = 8'(INITIAL_JUMP_VELOCITY - int'(speed >> 3));
            next_gravity_acc = '0;
        end else if (state == JUMPING && next_state == RUNNING) begin
            next_y = pos_t'(GROUND_Y_POS);
        end else if (state == JUMPING && next_state == JUMPING) begin
            next_y = pos_t'(y_moved);
            if (gravity_sum >= 5'd10) begin
                next_gravity_acc = gravity_sum - 5'd10;
                next_velocity = velocity + 8'sd1;
            end else begin
                next_gravity_acc = gravity_sum;
            end
            // Clamp applies to the velocity after gravity.
            if (y_pos < pos_t'(MIN_JUMP_HEIGHT) && next_velocity < DROP_VELOCITY) begin
                next_velocity = 8'(DROP_VELOCITY);
            end
        end
    end

    // Frame follows the state being entered.
    always_comb begin
        case (next_state)
            WAITING: next_frame = (anim >= 6'd30) ? WAITING0 : WAITING1;
            RUNNING: next_frame = ((anim % 6'd10) < 6'd5) ? RUNNING0 : RUNNING1;
            JUMPING: next_frame = JUMPING0;
            DUCKING: next_frame = ((anim % 6'd20) < 6'd10) ? DUCKING0 : DUCKING1;
            default: next_frame = CRASHED0;
        endcase
    end

    // Ducking body is wider and sits lower.
    always_comb begin
        if (next_state == DUCKING) begin
            next_box_y = next_y + pos_t'(HEIGHT - HEIGHT_DUCK);
            next_box_w = pos_t'(WIDTH_DUCK);
            next_box_h = pos_t'(HEIGHT_DUCK);
        end else begin
            next_box_y = next_y;
            next_box_w = pos_t'(WIDTH);
            next_box_h = pos_t'(HEIGHT);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= WAITING;
            frame <= WAITING0;
            y_pos <= pos_t'(GROUND_Y_POS);
            velocity <= '0;
            gravity_acc <= '0;
            box.x <= pos_t'(START_X_POS);
            box.y <= pos_t'(GROUND_Y_POS);
            box.w <= pos_t'(WIDTH);
            box.h <= pos_t'(HEIGHT);
        end else if (tick) begin
            state <= next_state;
            frame <= next_frame;
            y_pos <= next_y;
            velocity <= next_velocity;
            gravity_acc <= next_gravity_acc;
            box.x <= x_pos;
            box.y <= next_box_y;
            box.w <= next_box_w;
            box.h <= next_box_h;
        end
    end

endmodule

// File: design/frame_timer.sv
module frame_timer #(
    parameter int CLK_PER_FRAME = 100_000_000 / 60
) (
    input  logic       clk,
    input  logic       rst,
    output logic       tick,
    output logic [5:0] anim
);
    import game_pkg::*;

    localparam int CNT_W = $clog2(CLK_PER_FRAME + 1);

    logic [CNT_W-1:0] clk_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            clk_cnt <= '0;
            tick <= 1'b0;
            anim <= '0;
        end else begin
            tick <= 1'b0;
            if (clk_cnt == CNT_W'(CLK_PER_FRAME - 1)) begin
                clk_cnt <= '0;
                tick <= 1'b1;
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end
            // Animation counter steps in the tick cycle.
            if (tick) begin
                anim <= (anim == 6'(FRAME_COUNT - 1)) ? 6'd0 : anim + 6'd1;
            end
        end
    end

endmodule

// File: design/box_if.sv
interface box_if;
    import game_pkg::*;

    // Top left corner and size.
    pos_t x;
    pos_t y;
    pos_t w;
    pos_t h;

    modport source (
        output x,
        output y,
        output w,
        output h
    );

    modport sink (
        input x,
        input y,
        input w,
        input h
    );

endinterface

// File: design/trex_pkg.sv
package trex_pkg;

    typedef enum logic [2:0] {
        WAITING,
        RUNNING,
        JUMPING,
        DUCKING,
        CRASHED
    } state_t;

    typedef enum logic [2:0] {
        WAITING0,
        WAITING1,
        RUNNING0,
        RUNNING1,
        JUMPING0,
        DUCKING0,
        DUCKING1,
        CRASHED0
    } frame_t;

    // Body size, standing and ducking.
    localparam int HEIGHT = 47;
    localparam int HEIGHT_DUCK = 25;
    localparam int WIDTH = 44;
    localparam int WIDTH_DUCK = 59;

    localparam int START_X_POS = 50;

    // Top of the body when standing on the ground.
    localparam int GROUND_Y_POS = game_pkg::GROUND_LINE - HEIGHT;

    // Jump physics, negative velocity moves up the screen.
    localparam int GRAVITY = 6;
    localparam int INITIAL_JUMP_VELOCITY = -10;
    localparam int DROP_VELOCITY = -5;

    // Above this height the climb is limited to the drop velocity.
    localparam int MIN_JUMP_HEIGHT = GROUND_Y_POS - 30;

endpackage

// File: design/game_pkg.sv
package game_pkg;

    // Pixel coordinate on the playfield.
    typedef logic [9:0] pos_t;

    // Playfield width, also where a new cactus appears.
    localparam int SCREEN_WIDTH = 600;

    // Top of the ground surface.
    localparam int GROUND_LINE = 140;

    // Cactus bounding box.
    localparam int OBST_WIDTH = 17;
    localparam int OBST_HEIGHT = 35;

    // The cactus stands on the ground line.
    localparam int OBST_Y_POS = GROUND_LINE - OBST_HEIGHT;

    // Scroll step at speed 0, in pixels per frame.
    localparam int BASE_SCROLL = 4;

    // Animation period in frames.
    localparam int FRAME_COUNT = 60;

endpackage
